//--- source/wasm_pkg.sv
`default_nettype none

package wasm_pkg;

  // Program memory geometry
  localparam int MEM_ADDR_BITS = 6;
  localparam int MEM_BYTES     = 2 ** MEM_ADDR_BITS;
  // One extra PC bit so a run past the end is visible
  localparam int PC_BITS       = MEM_ADDR_BITS + 1;
  // Opcode plus up to nine LEB128 bytes
  localparam int WINDOW_BYTES  = 10;

  // Operand stack
  localparam int STACK_DEPTH = 8;
  localparam int COUNT_BITS  = 4;

  // The same 64 bits are read as i64 or as i32 depending on the type tag
  typedef union packed {
    logic [63:0] i64;
    struct packed {
      logic [31:0] upper;
      logic [31:0] low;
    } i32;
  } value_word_t;

  // Codes 2 and 3 are reserved
  typedef enum logic [1:0] {
    I32 = 2'd0,
    I64 = 2'd1
  } value_type_t;

  typedef struct packed {
    value_type_t vtype;
    value_word_t value;
  } stack_entry_t;

  typedef enum logic [2:0] {
    S_NONE,
    S_PUSH,
    S_POP,
    S_REPLACE,
    S_POP_REPLACE,
    S_POP2_REPLACE
  } stack_op_t;

  typedef enum logic [7:0] {
    OP_UNREACHABLE = 8'h00, OP_NOP       = 8'h01, OP_END       = 8'h0b,
    OP_RETURN      = 8'h0f, OP_DROP      = 8'h1a, OP_SELECT    = 8'h1b,
    OP_I32_CONST   = 8'h41, OP_I64_CONST = 8'h42, OP_I32_EQZ   = 8'h45,
    OP_I32_EQ      = 8'h46, OP_I32_NE    = 8'h47, OP_I64_EQZ   = 8'h50,
    OP_I64_EQ      = 8'h51, OP_I64_NE    = 8'h52, OP_I32_ADD   = 8'h6a,
    OP_I32_SUB     = 8'h6b, OP_I64_ADD   = 8'h7c, OP_I64_SUB   = 8'h7d
  } opcode_t;

  typedef enum logic [3:0] {
    NONE = 4'd0,
    ENDED,
    UNREACHABLE,
    UNKNOWN_OPCODE,
    TYPE_MISMATCH,
    STACK_EMPTY,
    STACK_FULL,
    ROM_ERROR
  } trap_t;

endpackage

`default_nettype wire

//--- source/stack_if.sv
`timescale 1ns/100ps
`default_nettype none

interface stack_if import wasm_pkg::*; ();

  // Operation request from the controller
  stack_op_t    op;
  stack_entry_t data;

  // Top three entries and the fill level
  stack_entry_t tos;
  stack_entry_t nos;
  stack_entry_t third;
  logic [COUNT_BITS-1:0] count;

  modport ctrl (
    output op, data,
    input  tos, nos, third, count
  );

  modport store (
    input  op, data,
    output tos, nos, third, count
  );

endinterface

`default_nettype wire

//--- source/program_memory.sv
`timescale 1ns/100ps
`default_nettype none

module program_memory import wasm_pkg::*; (
  input  logic                      clk,
  input  logic                      prog_write,
  input  logic [MEM_ADDR_BITS-1:0]  prog_addr,
  input  logic [7:0]                prog_byte,
  input  logic [PC_BITS-1:0]        fetch_addr,
  output logic [WINDOW_BYTES*8-1:0] window,
  output logic                      window_error
);

  logic [7:0]                mem [MEM_BYTES];
  logic [WINDOW_BYTES*8-1:0] window_next;
  logic [PC_BITS:0]          byte_addr;

  // Byte writes are accepted in any cycle
  always_ff @(posedge clk) begin
    if (prog_write) begin
      mem[prog_addr] <= prog_byte;
    end
  end

  // Gather the window, byte 0 is the opcode in the low bits
  always_comb begin
    byte_addr = '0;
    for (int i = 0; i < WINDOW_BYTES; i++) begin
      byte_addr = {1'b0, fetch_addr} + (PC_BITS + 1)'(i);
      if (byte_addr < MEM_BYTES) begin
        window_next[8*i +: 8] = mem[byte_addr[MEM_ADDR_BITS-1:0]];
      end else begin
        window_next[8*i +: 8] = 8'h00;
      end
    end
  end

  always_ff @(posedge clk) begin
    window       <= window_next;
    window_error <= fetch_addr >= MEM_BYTES;
  end

endmodule

`default_nettype wire

//--- source/leb128_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module leb128_decoder import wasm_pkg::*; (
  input  logic [71:0] bytes,
  output logic [63:0] value,
  output logic [3:0]  length
);

  logic done;
  logic sign;

  always_comb begin
    done   = 1'b0;
    sign   = 1'b0;
    length = 4'd9;
    value  = '0;

    // Collect 7-bit groups up to the first byte without continuation
    for (int k = 0; k < 9; k++) begin
      if (!done) begin
        value[7*k +: 7] = bytes[8*k +: 7];
        sign            = bytes[8*k + 6];
        if (!bytes[8*k + 7]) begin
          done   = 1'b1;
          length = 4'(k + 1);
        end
      end
    end

    // Sign extension above the last group
    for (int b = 0; b < 64; b++) begin
      if (b >= 7 * int'(length)) begin
        value[b] = sign;
      end
    end
  end

endmodule

`default_nettype wire

//--- source/operand_stack.sv
`timescale 1ns/100ps
`default_nettype none

module operand_stack import wasm_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  stack_if.store  stk
);

  // Entry 0 is the top of stack, deeper entries follow
  stack_entry_t entries [STACK_DEPTH];

  always_ff @(posedge clk) begin
    case (stk.op)
      S_PUSH: begin
        entries[0] <= stk.data;
        for (int i = 1; i < STACK_DEPTH; i++) begin
          entries[i] <= entries[i-1];
        end
      end
      S_POP: begin
        for (int i = 0; i < STACK_DEPTH - 1; i++) begin
          entries[i] <= entries[i+1];
        end
        entries[STACK_DEPTH-1] <= '0;
      end
      S_REPLACE: begin
        entries[0] <= stk.data;
      end
      S_POP_REPLACE: begin
        entries[0] <= stk.data;
        for (int i = 1; i < STACK_DEPTH - 1; i++) begin
          entries[i] <= entries[i+1];
        end
        entries[STACK_DEPTH-1] <= '0;
      end
      S_POP2_REPLACE: begin
        entries[0] <= stk.data;
        for (int i = 1; i < STACK_DEPTH - 2; i++) begin
          entries[i] <= entries[i+2];
        end
        entries[STACK_DEPTH-2] <= '0;
        entries[STACK_DEPTH-1] <= '0;
      end
      default: begin
      end
    endcase
  end

  // Fill level, limits are enforced by the controller
  always_ff @(posedge clk) begin
    if (reset) begin
      stk.count <= '0;
    end else begin
      case (stk.op)
        S_PUSH:                stk.count <= stk.count + 1'b1;
        S_POP, S_POP_REPLACE:  stk.count <= stk.count - 1'b1;
        S_POP2_REPLACE:        stk.count <= stk.count - 2'd2;
        default:               stk.count <= stk.count;
      endcase
    end
  end

  assign stk.tos   = entries[0];
  assign stk.nos   = entries[1];
  assign stk.third = entries[2];

endmodule

`default_nettype wire

//--- source/integer_alu.sv
`timescale 1ns/100ps
`default_nettype none

module integer_alu import wasm_pkg::*; (
  input  opcode_t      opcode,
  input  stack_entry_t tos,
  input  stack_entry_t nos,
  output stack_entry_t result,
  output logic         type_ok
);

  logic both_i32;
  logic both_i64;

  // b is the top of stack, a the entry below
  assign both_i32 = (tos.vtype == I32) && (nos.vtype == I32);
  assign both_i64 = (tos.vtype == I64) && (nos.vtype == I64);

  always_comb begin
    result       = '0;
    result.vtype = I32;
    type_ok      = 1'b0;
    case (opcode)
      OP_I32_EQZ: begin
        type_ok               = tos.vtype == I32;
        result.value.i32.low  = {31'd0, tos.value.i32.low == 32'd0};
      end
      OP_I64_EQZ: begin
        type_ok               = tos.vtype == I64;
        result.value.i32.low  = {31'd0, tos.value.i64 == 64'd0};
      end
      OP_I32_EQ, OP_I32_NE: begin
        type_ok               = both_i32;
        result.value.i32.low  = {31'd0, (nos.value.i32.low == tos.value.i32.low) ^
                                        (opcode == OP_I32_NE)};
      end
      OP_I64_EQ, OP_I64_NE: begin
        type_ok               = both_i64;
        result.value.i32.low  = {31'd0, (nos.value.i64 == tos.value.i64) ^
                                        (opcode == OP_I64_NE)};
      end
      OP_I32_ADD: begin
        type_ok               = both_i32;
        result.value.i32.low  = nos.value.i32.low + tos.value.i32.low;
      end
      OP_I32_SUB: begin
        type_ok               = both_i32;
        result.value.i32.low  = nos.value.i32.low - tos.value.i32.low;
      end
      OP_I64_ADD, OP_I64_SUB: begin
        type_ok               = both_i64;
        result.vtype          = I64;
        result.value.i64      = (opcode == OP_I64_ADD) ? nos.value.i64 + tos.value.i64
                                                       : nos.value.i64 - tos.value.i64;
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

//--- source/exec_control.sv
`timescale 1ns/100ps
`default_nettype none

module exec_control import wasm_pkg::*; (
  input  logic                      clk,
  input  logic                      reset,
  output logic [PC_BITS-1:0]        fetch_addr,
  input  logic [WINDOW_BYTES*8-1:0] window,
  input  logic                      window_error,
  input  logic [63:0]               imm_value,
  input  logic [3:0]                imm_length,
  output opcode_t                   alu_opcode,
  input  stack_entry_t              alu_result,
  input  logic                      alu_type_ok,
  stack_if.ctrl                     stk,
  output trap_t                     trap
);

  logic                  executing;
  logic [PC_BITS-1:0]    pc;
  logic [PC_BITS-1:0]    pc_next;
  logic [COUNT_BITS-1:0] need;
  logic                  pushes;
  opcode_t               opcode;
  trap_t                 trap_next;

  assign fetch_addr = pc;
  assign opcode     = opcode_t'(window[7:0]);
  assign alu_opcode = opcode;

  // Entries each opcode consumes and whether it adds one
  always_comb begin
    need   = '0;
    pushes = 1'b0;
    case (opcode)
      OP_DROP, OP_I32_EQZ, OP_I64_EQZ:       need = COUNT_BITS'(1);
      OP_I32_EQ, OP_I32_NE, OP_I64_EQ, OP_I64_NE,
      OP_I32_ADD, OP_I32_SUB, OP_I64_ADD, OP_I64_SUB: need = COUNT_BITS'(2);
      OP_SELECT:                             need = COUNT_BITS'(3);
      OP_I32_CONST, OP_I64_CONST:            pushes = 1'b1;
      default: begin
      end
    endcase
  end

  always_comb begin
    stk.op    = S_NONE;
    stk.data  = alu_result;
    trap_next = NONE;
    pc_next   = pc + 1'b1;

    if (window_error) begin
      trap_next = ROM_ERROR;
    end else if (stk.count < need) begin
      trap_next = STACK_EMPTY;
    end else if (pushes && stk.count == COUNT_BITS'(STACK_DEPTH)) begin
      trap_next = STACK_FULL;
    end else begin
      case (opcode)
        OP_UNREACHABLE: trap_next = UNREACHABLE;
        OP_NOP: begin
        end
        OP_END, OP_RETURN: trap_next = ENDED;
        OP_DROP: stk.op = S_POP;
        OP_SELECT: begin
          // Condition on top, val2 below it, val1 deepest
          if (stk.tos.vtype != I32 || stk.nos.vtype != stk.third.vtype) begin
            trap_next = TYPE_MISMATCH;
          end else begin
            stk.op   = S_POP2_REPLACE;
            stk.data = (stk.tos.value.i32.low != 32'd0) ? stk.third : stk.nos;
          end
        end
        OP_I32_CONST, OP_I64_CONST: begin
          stk.op   = S_PUSH;
          pc_next  = pc + 1'b1 + PC_BITS'(imm_length);
          if (opcode == OP_I32_CONST) begin
            stk.data.vtype           = I32;
            stk.data.value.i32.upper = 32'd0;
            stk.data.value.i32.low   = imm_value[31:0];
          end else begin
            stk.data.vtype     = I64;
            stk.data.value.i64 = imm_value;
          end
        end
        OP_I32_EQZ, OP_I64_EQZ, OP_I32_EQ, OP_I32_NE, OP_I64_EQ, OP_I64_NE,
        OP_I32_ADD, OP_I32_SUB, OP_I64_ADD, OP_I64_SUB: begin
          if (!alu_type_ok) begin
            trap_next = TYPE_MISMATCH;
          end else if (need == COUNT_BITS'(1)) begin
            stk.op = S_REPLACE;
          end else begin
            stk.op = S_POP_REPLACE;
          end
        end
        default: trap_next = UNKNOWN_OPCODE;
      endcase
    end

    // Stack only moves in EXEC of a running program
    if (!executing) begin
      stk.op = S_NONE;
    end
  end

  // FETCH and EXEC alternate until a trap is raised
  always_ff @(posedge clk) begin
    if (reset) begin
      executing <= 1'b0;
      pc        <= '0;
      trap      <= NONE;
    end else if (trap == NONE) begin
      executing <= !executing;
      if (executing) begin
        pc   <= pc_next;
        trap <= trap_next;
      end
    end
  end

endmodule

`default_nettype wire

//--- source/wasm_core_top.sv
`timescale 1ns/100ps
`default_nettype none

module wasm_core_top import wasm_pkg::*; (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     prog_write,
  input  logic [MEM_ADDR_BITS-1:0] prog_addr,
  input  logic [7:0]               prog_byte,
  output logic [63:0]              result,
  output logic [1:0]               result_type,
  output logic                     result_empty,
  output logic [3:0]               trap
);

  logic [PC_BITS-1:0]        fetch_addr;
  logic [WINDOW_BYTES*8-1:0] window;
  logic                      window_error;
  logic [63:0]               imm_value;
  logic [3:0]                imm_length;
  opcode_t                   alu_opcode;
  stack_entry_t              alu_result;
  logic                      alu_type_ok;
  trap_t                     core_trap;

  stack_if stk ();

  program_memory u_program_memory (
    .clk          (clk),
    .prog_write   (prog_write),
    .prog_addr    (prog_addr),
    .prog_byte    (prog_byte),
    .fetch_addr   (fetch_addr),
    .window       (window),
    .window_error (window_error)
  );

  // Immediate bytes follow the opcode byte
  leb128_decoder u_leb128_decoder (
    .bytes  (window[WINDOW_BYTES*8-1:8]),
    .value  (imm_value),
    .length (imm_length)
  );

  operand_stack u_operand_stack (
    .clk   (clk),
    .reset (reset),
    .stk   (stk.store)
  );

  integer_alu u_integer_alu (
    .opcode  (alu_opcode),
    .tos     (stk.tos),
    .nos     (stk.nos),
    .result  (alu_result),
    .type_ok (alu_type_ok)
  );

  exec_control u_exec_control (
    .clk          (clk),
    .reset        (reset),
    .fetch_addr   (fetch_addr),
    .window       (window),
    .window_error (window_error),
    .imm_value    (imm_value),
    .imm_length   (imm_length),
    .alu_opcode   (alu_opcode),
    .alu_result   (alu_result),
    .alu_type_ok  (alu_type_ok),
    .stk          (stk.ctrl),
    .trap         (core_trap)
  );

  assign result       = stk.tos.value.i64;
  assign result_type  = stk.tos.vtype;
  assign result_empty = stk.count == '0;
  assign trap         = core_trap;

endmodule

`default_nettype wire

//--- verification/wasm_model.svh
`ifndef WASM_MODEL_SVH
`define WASM_MODEL_SVH
`default_nettype none

// Program image and the expected machine state after it stops
logic [7:0]  prog_bytes [$];
logic [1:0]  model_type [STACK_DEPTH];
logic [63:0] model_val  [STACK_DEPTH];
int          model_count;
trap_t       model_trap;

function automatic void clear_program();
  prog_bytes.delete();
  model_count = 0;
  model_trap  = NONE;
endfunction

// Shortest signed LEB128 form
function automatic void append_leb(logic [63:0] v);
  logic [63:0] rest;
  logic [7:0]  b;
  logic        done;
  rest = v;
  done = 1'b0;
  while (!done) begin
    b    = {1'b0, rest[6:0]};
    rest = $signed(rest) >>> 7;
    if ((rest == '0 && !b[6]) || (rest == '1 && b[6])) begin
      done = 1'b1;
    end else begin
      b[7] = 1'b1;
    end
    prog_bytes.push_back(b);
  end
endfunction

// Small values, values around the sign bit, or anything
function automatic logic [63:0] pick_value(logic is64, int style);
  logic [63:0] v;
  v = {$random(seed), $random(seed)};
  case (style)
    0: v = {{60{v[3]}}, v[3:0]};
    1: begin
      if (is64) begin
        v = 64'h4000_0000_0000_0000 + {{59{v[4]}}, v[4:0]};
      end else begin
        v = 64'h0000_0000_8000_0000 + {{59{v[4]}}, v[4:0]};
      end
    end
    default: begin
    end
  endcase
  // Nine immediate bytes carry 63 bits
  if (is64) begin
    v[63] = v[62];
  end
  return v;
endfunction

function automatic logic [7:0] binary_op(logic is64, int kind);
  case (kind)
    0:       return is64 ? OP_I64_ADD : OP_I32_ADD;
    1:       return is64 ? OP_I64_SUB : OP_I32_SUB;
    2:       return is64 ? OP_I64_EQ : OP_I32_EQ;
    default: return is64 ? OP_I64_NE : OP_I32_NE;
  endcase
endfunction

function automatic void add_const(logic is64, logic [63:0] v);
  prog_bytes.push_back(is64 ? OP_I64_CONST : OP_I32_CONST);
  append_leb(is64 ? v : {{32{v[31]}}, v[31:0]});
  if (model_trap != NONE) return;
  if (model_count == STACK_DEPTH) begin
    model_trap = STACK_FULL;
  end else begin
    model_type[model_count] = is64 ? I64 : I32;
    model_val[model_count]  = is64 ? v : {32'd0, v[31:0]};
    model_count++;
  end
endfunction

function automatic void add_op(logic [7:0] op);
  int          top;
  logic        wide;
  logic [63:0] a;
  logic [63:0] b;
  logic [63:0] r;
  prog_bytes.push_back(op);
  if (model_trap != NONE) return;
  top  = model_count - 1;
  wide = op inside {OP_I64_EQZ, OP_I64_EQ, OP_I64_NE, OP_I64_ADD, OP_I64_SUB};
  case (op)
    OP_UNREACHABLE: model_trap = UNREACHABLE;
    OP_NOP: begin
    end
    OP_END, OP_RETURN: model_trap = ENDED;
    OP_DROP: begin
      if (model_count < 1) model_trap = STACK_EMPTY;
      else model_count--;
    end
    OP_SELECT: begin
      // Condition on top, then val2, then val1
      if (model_count < 3) begin
        model_trap = STACK_EMPTY;
      end else if (model_type[top] != I32 || model_type[top-1] != model_type[top-2]) begin
        model_trap = TYPE_MISMATCH;
      end else begin
        if (model_val[top] == 64'd0) begin
          model_val[top-2]  = model_val[top-1];
          model_type[top-2] = model_type[top-1];
        end
        model_count -= 2;
      end
    end
    OP_I32_EQZ, OP_I64_EQZ: begin
      if (model_count < 1) begin
        model_trap = STACK_EMPTY;
      end else if (model_type[top] != (wide ? I64 : I32)) begin
        model_trap = TYPE_MISMATCH;
      end else begin
        model_val[top]  = (model_val[top] == 64'd0) ? 64'd1 : 64'd0;
        model_type[top] = I32;
      end
    end
    OP_I32_EQ, OP_I32_NE, OP_I64_EQ, OP_I64_NE,
    OP_I32_ADD, OP_I32_SUB, OP_I64_ADD, OP_I64_SUB: begin
      if (model_count < 2) begin
        model_trap = STACK_EMPTY;
      end else if (model_type[top] != (wide ? I64 : I32) ||
                   model_type[top-1] != (wide ? I64 : I32)) begin
        model_trap = TYPE_MISMATCH;
      end else begin
        a = model_val[top-1];
        b = model_val[top];
        case (op)
          OP_I32_ADD, OP_I64_ADD: r = a + b;
          OP_I32_SUB, OP_I64_SUB: r = a - b;
          OP_I32_EQ, OP_I64_EQ:   r = {63'd0, a == b};
          default:                r = {63'd0, a != b};
        endcase
        if (!wide) r[63:32] = 32'd0;
        model_val[top-1]  = r;
        model_type[top-1] = (op == OP_I64_ADD || op == OP_I64_SUB) ? I64 : I32;
        model_count--;
      end
    end
    default: model_trap = UNKNOWN_OPCODE;
  endcase
endfunction

// A program that never stops runs off the end of memory
function automatic void close_program();
  if (model_trap == NONE) model_trap = ROM_ERROR;
endfunction

`default_nettype wire
`endif

//--- verification/wasm_core_tb.sv
`timescale 1ns/100ps
`default_nettype none

module wasm_core_tb import wasm_pkg::*; ();

  logic                     clk;
  logic                     reset;
  logic                     prog_write;
  logic [MEM_ADDR_BITS-1:0] prog_addr;
  logic [7:0]               prog_byte;
  logic [63:0]              result;
  logic [1:0]               result_type;
  logic                     result_empty;
  logic [3:0]               trap;

  int seed;
  int pass_count;
  int fail_count;

  `include "wasm_model.svh"

  wasm_core_top DUT (
    .clk          (clk),
    .reset        (reset),
    .prog_write   (prog_write),
    .prog_addr    (prog_addr),
    .prog_byte    (prog_byte),
    .result       (result),
    .result_type  (result_type),
    .result_empty (result_empty),
    .trap         (trap)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // Load the program under reset, run it and compare the final state
  task automatic run_program(input string name);
    int cycles;
    bit ok;
    close_program();
    reset = 1'b1;
    for (int a = 0; a < MEM_BYTES; a++) begin
      next_cycle();
      prog_write = 1'b1;
      prog_addr  = MEM_ADDR_BITS'(a);
      prog_byte  = (a < prog_bytes.size()) ? prog_bytes[a] : OP_NOP;
    end
    next_cycle();
    prog_write = 1'b0;
    repeat (4) next_cycle();
    reset = 1'b0;

    cycles = 0;
    while (trap == NONE && cycles < 500) begin
      next_cycle();
      cycles++;
    end

    ok = 1'b1;
    if (trap == NONE) begin
      $display("%s: no trap raised within 500 cycles", name);
      ok = 1'b0;
    end else begin
      if (trap !== model_trap) begin
        $display("FAILED %s trap: expected %0d actual %0d", name, model_trap, trap);
        ok = 1'b0;
      end
      if (result_empty !== (model_count == 0)) begin
        $display("FAILED %s result_empty: expected %b actual %b",
                 name, model_count == 0, result_empty);
        ok = 1'b0;
      end
      // Stale entries show on result when the stack is empty
      if (model_count > 0) begin
        if (result !== model_val[model_count-1]) begin
          $display("FAILED %s result: expected %h actual %h",
                   name, model_val[model_count-1], result);
          ok = 1'b0;
        end
        if (result_type !== model_type[model_count-1]) begin
          $display("FAILED %s result_type: expected %0d actual %0d",
                   name, model_type[model_count-1], result_type);
          ok = 1'b0;
        end
      end
    end
    if (ok) begin
      pass_count++;
      $display("passed %s", name);
    end else begin
      fail_count++;
    end
  endtask

  initial begin
    logic        is64;
    int          kind;
    logic [63:0] a_val;
    seed         = 28299;
    pass_count   = 0;
    fail_count   = 0;
    reset        = 1'b1;
    prog_write   = 1'b0;
    prog_addr    = '0;
    prog_byte    = '0;

    for (int i = 0; i < 20; i++) begin
      is64 = 1'($random(seed));
      clear_program();
      add_const(is64, pick_value(is64, i % 3));
      add_op(OP_END);
      run_program($sformatf("const_end_%0d", i));
    end

    for (int i = 0; i < 40; i++) begin
      is64  = 1'($random(seed));
      kind  = $unsigned($random(seed)) % 5;
      a_val = pick_value(is64, i % 3);
      clear_program();
      add_const(is64, a_val);
      if (kind == 4) begin
        add_op(is64 ? OP_I64_EQZ : OP_I32_EQZ);
      end else begin
        // Equal operands now and then so eq and ne see both outcomes
        add_const(is64, ($random(seed) & 1) ? a_val : pick_value(is64, i % 3));
        add_op(binary_op(is64, kind));
      end
      add_op(OP_END);
      run_program($sformatf("alu_%0d", i));
    end

    for (int i = 0; i < 6; i++) begin
      is64 = 1'($random(seed));
      clear_program();
      add_const(is64, pick_value(is64, 2));
      add_const(is64, pick_value(is64, 2));
      add_const(1'b0, ($random(seed) & 1) ? 64'd0 : pick_value(1'b0, 2));
      add_op(OP_SELECT);
      add_op(OP_END);
      run_program($sformatf("select_%0d", i));
    end

    clear_program();
    add_const(1'b1, pick_value(1'b1, 2));
    add_const(1'b0, pick_value(1'b0, 2));
    add_op(OP_DROP);
    add_op(OP_END);
    run_program("drop_keeps_first");

    // Error traps
    clear_program();
    add_const(1'b0, pick_value(1'b0, 2));
    add_const(1'b1, pick_value(1'b1, 2));
    add_op(OP_I32_ADD);
    add_op(OP_END);
    run_program("type_mismatch");

    clear_program();
    add_op(OP_DROP);
    run_program("stack_empty");

    clear_program();
    add_op(OP_UNREACHABLE);
    run_program("unreachable");

    clear_program();
    add_op(8'hff);
    run_program("unknown_opcode");

    clear_program();
    for (int i = 0; i < 9; i++) begin
      add_const(1'b0, pick_value(1'b0, i % 3));
    end
    add_op(OP_END);
    run_program("stack_full");

    // No end, so the PC walks through the nop fill
    clear_program();
    add_const(1'b0, pick_value(1'b0, 2));
    run_program("rom_error");

    $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+verification
source/wasm_pkg.sv
source/stack_if.sv
source/program_memory.sv
source/leb128_decoder.sv
source/operand_stack.sv
source/integer_alu.sv
source/exec_control.sv
source/wasm_core_top.sv
verification/wasm_core_tb.sv

//--- Bender.yml
package:
  name: wasm_core

sources:
  - files:
      - source/wasm_pkg.sv
      - source/stack_if.sv
      - source/program_memory.sv
      - source/leb128_decoder.sv
      - source/operand_stack.sv
      - source/integer_alu.sv
      - source/exec_control.sv
      - source/wasm_core_top.sv
  - target: simulation
    include_dirs:
      - verification
    files:
      - verification/wasm_core_tb.sv
